//--- verilog/mem_pkg.sv
package mem_pkg;

    // ==================================================
    // Channel layout
    // ==================================================

    localparam int NUM_CH   = 4;    // Ch 0 is the ROM loader, ch 1..3 serve clients
    localparam int CH_IDX_W = 2;    // Index width for NUM_CH channels

    // ==================================================
    // Word store geometry
    // ==================================================

    localparam int ADDR_W = 10;                 // Word address
    localparam int DATA_W = 16;                 // One 16-bit SDRAM-style word
    localparam int BYTE_W = 8;                  // Lane width for byte enables
    localparam int BE_W   = DATA_W / BYTE_W;    // Two byte lanes per word

    // Download stream addresses bytes, so one extra bit over the word address
    localparam int LOAD_ADDR_W = ADDR_W + 1;

    // Fixed store access time, start to valid
    localparam int MEM_LAT = 3;

endpackage

//--- verilog/rom_loader.sv
`timescale 1ns/1ps

module rom_loader import mem_pkg::*; (
    input  logic                   clk_sys,
    input  logic                   rst_n,

    // Host download stream, one byte per strobe
    input  logic                   ioctl_download,
    input  logic                   ioctl_wr,
    input  logic [LOAD_ADDR_W-1:0] ioctl_addr,
    input  logic [BYTE_W-1:0]      ioctl_data,
    output logic                   ioctl_wait,      // Holds the host off
    output logic                   busy,

    // Channel 0 client side
    output logic                   ld_req,
    output logic [ADDR_W-1:0]      ld_addr,
    output logic [DATA_W-1:0]      ld_din,
    output logic [BE_W-1:0]        ld_be,
    output logic                   ld_rnw,
    input  logic                   ld_ack
);

    // Write cycle sequencer
    typedef enum logic [1:0] {
        LD_IDLE,    // Waiting for a strobe
        LD_REQ,     // req high, waiting for ack
        LD_REL      // req dropped, waiting for ack to fall
    } ld_state_t;

    ld_state_t state;

    logic take_byte;
    logic odd_byte;

    // Strobes only count while idle, the host should be stalled otherwise
    assign take_byte = (state == LD_IDLE) && ioctl_wr;
    assign odd_byte  = ioctl_addr[0];    // Odd byte lands in the high lane

    // Loader only ever writes
    assign ld_rnw = 1'b0;

    // ==================================================
    // Control
    // ==================================================

    always_ff @(posedge clk_sys or negedge rst_n) begin
        if (!rst_n) begin
            state      <= LD_IDLE;
            ld_req     <= 1'b0;
            ioctl_wait <= 1'b0;
            busy       <= 1'b0;
        end else begin
            case (state)
                LD_IDLE: begin
                    if (ioctl_wr) begin
                        ld_req     <= 1'b1;
                        ioctl_wait <= 1'b1;    // Raised on the edge after the strobe
                        state      <= LD_REQ;
                    end
                end
                LD_REQ: begin
                    if (ld_ack) begin
                        ld_req <= 1'b0;        // Phase 3
                        state  <= LD_REL;
                    end
                end
                LD_REL: begin
                    // Four-phase cycle closes once ack is seen low
                    if (!ld_ack) begin
                        ioctl_wait <= 1'b0;
                        state      <= LD_IDLE;
                    end
                end
                default: state <= LD_IDLE;
            endcase

            // Busy from the first byte until the last write has drained
            if (ioctl_wr) begin
                busy <= 1'b1;
            end else if (state == LD_IDLE && !ioctl_download) begin
                busy <= 1'b0;
            end
        end
    end

    // Byte to word mapping, held stable for the whole cycle
    always_ff @(posedge clk_sys) begin
        if (take_byte) begin
            ld_addr <= ioctl_addr[LOAD_ADDR_W-1:1];    // Word = byte address / 2
            if (odd_byte) begin
                ld_din <= {ioctl_data, {BYTE_W{1'b0}}};
                ld_be  <= 2'b10;
            end else begin
                ld_din <= {{BYTE_W{1'b0}}, ioctl_data};
                ld_be  <= 2'b01;
            end
        end
    end

endmodule

//--- verilog/mem_channel.sv
`timescale 1ns/1ps

module mem_channel import mem_pkg::*; (
    input  logic              clk_sys,
    input  logic              rst_n,

    // Client side, four-phase req/ack
    input  logic              req,
    input  logic [ADDR_W-1:0] addr,
    input  logic [DATA_W-1:0] din,
    input  logic [BE_W-1:0]   be,
    input  logic              rnw,       // 1 - read, 0 - write
    output logic              ack,
    output logic [DATA_W-1:0] dout,

    // Arbiter side
    output logic              pend,      // Level, held until done
    output logic [ADDR_W-1:0] pend_addr,
    output logic [DATA_W-1:0] pend_din,
    output logic [BE_W-1:0]   pend_be,
    output logic              pend_rnw,
    input  logic              done,      // One-cycle completion strobe
    input  logic [DATA_W-1:0] rdata
);

    logic accept;

    // New access only from the fully idle phase, so a held req
    // after ack cannot start a second access
    assign accept = req && !ack && !pend;

    // ==================================================
    // Handshake sequencing
    // ==================================================

    always_ff @(posedge clk_sys or negedge rst_n) begin
        if (!rst_n) begin
            pend <= 1'b0;
            ack  <= 1'b0;
        end else begin
            if (done) begin
                pend <= 1'b0;    // Falls the cycle after done
                ack  <= 1'b1;    // Phase 2
            end else if (accept) begin
                pend <= 1'b1;    // Phase 1 seen
            end else if (ack && !req) begin
                ack  <= 1'b0;    // Phase 4
            end
        end
    end

    // Snapshot of the request for the arbiter
    always_ff @(posedge clk_sys) begin
        if (accept) begin
            pend_addr <= addr;
            pend_din  <= din;
            pend_be   <= be;
            pend_rnw  <= rnw;
        end
    end

    // Read word, valid from ack onwards
    always_ff @(posedge clk_sys) begin
        if (done) begin
            dout <= rdata;    // Don't care for writes
        end
    end

endmodule

//--- verilog/mem_arbiter.sv
`timescale 1ns/1ps

module mem_arbiter import mem_pkg::*; (
    input  logic                          clk_sys,
    input  logic                          rst_n,

    // From the channel ports
    input  logic [NUM_CH-1:0]             pend,
    input  logic [NUM_CH-1:0][ADDR_W-1:0] pend_addr,
    input  logic [NUM_CH-1:0][DATA_W-1:0] pend_din,
    input  logic [NUM_CH-1:0][BE_W-1:0]   pend_be,
    input  logic [NUM_CH-1:0]             pend_rnw,
    output logic [NUM_CH-1:0]             done,         // One-hot, one cycle
    output logic [DATA_W-1:0]             rdata,        // Shared by all channels

    // Store access
    output logic                          mem_start,
    output logic [ADDR_W-1:0]             mem_addr,
    output logic [DATA_W-1:0]             mem_wdata,
    output logic [BE_W-1:0]               mem_be,
    output logic                          mem_rnw,
    input  logic                          mem_valid,
    input  logic [DATA_W-1:0]             mem_rdata
);

    typedef enum logic [1:0] {
        ST_IDLE,    // Looking for a pending channel
        ST_WAIT,    // Access running in the store
        ST_DONE     // done pulse out, pend of winner still high
    } arb_state_t;

    arb_state_t state;

    logic [CH_IDX_W-1:0] last_win;    // Winner of the previous grant
    logic [CH_IDX_W-1:0] next_win;
    logic [CH_IDX_W-1:0] cand;
    logic                any_pend;
    logic                grant;

    // ==================================================
    // Round-robin search
    // ==================================================

    // Walk from the farthest candidate back to the one just after
    // last_win, so the nearest pending channel is the last one kept
    always_comb begin
        any_pend = 1'b0;
        next_win = last_win;
        cand     = '0;
        for (int k = NUM_CH; k >= 1; k--) begin
            cand = CH_IDX_W'((int'(last_win) + k) % NUM_CH);    // Wraps around
            if (pend[cand]) begin
                any_pend = 1'b1;
                next_win = cand;
            end
        end
    end

    assign grant = (state == ST_IDLE) && any_pend;

    // ==================================================
    // Access sequencing
    // ==================================================

    always_ff @(posedge clk_sys or negedge rst_n) begin
        if (!rst_n) begin
            state     <= ST_IDLE;
            last_win  <= CH_IDX_W'(NUM_CH - 1);    // Channel 0 searched first
            mem_start <= 1'b0;
            done      <= '0;
        end else begin
            mem_start <= 1'b0;    // Pulses only
            done      <= '0;
            case (state)
                ST_IDLE: begin
                    if (any_pend) begin
                        last_win  <= next_win;
                        mem_start <= 1'b1;    // Start on the edge after pend seen
                        state     <= ST_WAIT;
                    end
                end
                ST_WAIT: begin
                    if (mem_valid) begin
                        done[last_win] <= 1'b1;
                        state          <= ST_DONE;
                    end
                end
                // Channel clears pend on this edge, so no regrant of it
                ST_DONE: state <= ST_IDLE;
                default: state <= ST_IDLE;
            endcase
        end
    end

    // Fields of the winner, stable from start to valid
    always_ff @(posedge clk_sys) begin
        if (grant) begin
            mem_addr  <= pend_addr[next_win];
            mem_wdata <= pend_din[next_win];
            mem_be    <= pend_be[next_win];
            mem_rnw   <= pend_rnw[next_win];
        end
    end

    // Read word lines up with the done pulse
    always_ff @(posedge clk_sys) begin
        if (state == ST_WAIT && mem_valid) begin
            rdata <= mem_rdata;
        end
    end

endmodule

//--- verilog/mem_store.sv
`timescale 1ns/1ps

module mem_store import mem_pkg::*; (
    input  logic              clk_sys,
    input  logic              rst_n,
    input  logic              start,     // One-cycle access strobe
    input  logic [ADDR_W-1:0] addr,
    input  logic [DATA_W-1:0] wdata,
    input  logic [BE_W-1:0]   be,
    input  logic              rnw,       // 1 - read, 0 - write
    output logic              valid,     // MEM_LAT cycles after start
    output logic [DATA_W-1:0] rdata
);

    logic [DATA_W-1:0]  mem [2**ADDR_W];    // Stands in for the SDRAM array
    logic [MEM_LAT-1:0] vld_sr;             // Start travelling to valid
    logic [DATA_W-1:0]  rd_pipe [MEM_LAT];  // Read word, same delay as vld_sr

    // ==================================================
    // Latency pipe
    // ==================================================

    always_ff @(posedge clk_sys or negedge rst_n) begin
        if (!rst_n) begin
            vld_sr <= '0;
        end else begin
            vld_sr <= MEM_LAT'({vld_sr, start});    // Shift in at bit 0
        end
    end

    assign valid = vld_sr[MEM_LAT-1];
    assign rdata = rd_pipe[MEM_LAT-1];

    // Array access happens on the start edge
    always_ff @(posedge clk_sys) begin
        if (start) begin
            rd_pipe[0] <= mem[addr];    // Old word, before any write below
            if (!rnw) begin
                for (int b = 0; b < BE_W; b++) begin
                    if (be[b]) begin
                        mem[addr][b*BYTE_W +: BYTE_W] <= wdata[b*BYTE_W +: BYTE_W];
                    end
                end
            end
        end
        for (int s = 1; s < MEM_LAT; s++) begin
            rd_pipe[s] <= rd_pipe[s-1];
        end
    end

endmodule

//--- verilog/mem_subsys_top.sv
`timescale 1ns/1ps

module mem_subsys_top import mem_pkg::*; (
    input  logic                          clk_sys,
    input  logic                          rst_n,

    // Host ROM download
    input  logic                          ioctl_download,
    input  logic                          ioctl_wr,
    input  logic [LOAD_ADDR_W-1:0]        ioctl_addr,
    input  logic [BYTE_W-1:0]             ioctl_data,
    output logic                          ioctl_wait,
    output logic                          busy,

    // Client channels 1..NUM_CH-1, indexed by channel number
    input  logic [NUM_CH-1:1]             cl_req,
    input  logic [NUM_CH-1:1][ADDR_W-1:0] cl_addr,
    input  logic [NUM_CH-1:1][DATA_W-1:0] cl_din,
    input  logic [NUM_CH-1:1][BE_W-1:0]   cl_be,
    input  logic [NUM_CH-1:1]             cl_rnw,
    output logic [NUM_CH-1:1]             cl_ack,
    output logic [NUM_CH-1:1][DATA_W-1:0] cl_dout
);

    // Client side of every channel, slot 0 driven by the loader
    wire [NUM_CH-1:0]             ch_req;
    wire [NUM_CH-1:0][ADDR_W-1:0] ch_addr;
    wire [NUM_CH-1:0][DATA_W-1:0] ch_din;
    wire [NUM_CH-1:0][BE_W-1:0]   ch_be;
    wire [NUM_CH-1:0]             ch_rnw;
    wire [NUM_CH-1:0]             ch_ack;
    wire [NUM_CH-1:0][DATA_W-1:0] ch_dout;

    // Channel to arbiter
    wire [NUM_CH-1:0]             pend;
    wire [NUM_CH-1:0][ADDR_W-1:0] pend_addr;
    wire [NUM_CH-1:0][DATA_W-1:0] pend_din;
    wire [NUM_CH-1:0][BE_W-1:0]   pend_be;
    wire [NUM_CH-1:0]             pend_rnw;
    wire [NUM_CH-1:0]             done;
    wire [DATA_W-1:0]             arb_rdata;

    // Arbiter to store
    wire              mem_start;
    wire [ADDR_W-1:0] mem_addr;
    wire [DATA_W-1:0] mem_wdata;
    wire [BE_W-1:0]   mem_be;
    wire              mem_rnw;
    wire              mem_valid;
    wire [DATA_W-1:0] mem_rdata;

    // ==================================================
    // Channel wiring
    // ==================================================

    assign ch_req[NUM_CH-1:1]  = cl_req;
    assign ch_addr[NUM_CH-1:1] = cl_addr;
    assign ch_din[NUM_CH-1:1]  = cl_din;
    assign ch_be[NUM_CH-1:1]   = cl_be;
    assign ch_rnw[NUM_CH-1:1]  = cl_rnw;
    assign cl_ack  = ch_ack[NUM_CH-1:1];
    assign cl_dout = ch_dout[NUM_CH-1:1];    // Loader ignores its read data

    rom_loader u_loader (
        .clk_sys        (clk_sys),
        .rst_n          (rst_n),
        .ioctl_download (ioctl_download),
        .ioctl_wr       (ioctl_wr),
        .ioctl_addr     (ioctl_addr),
        .ioctl_data     (ioctl_data),
        .ioctl_wait     (ioctl_wait),
        .busy           (busy),
        .ld_req         (ch_req[0]),
        .ld_addr        (ch_addr[0]),
        .ld_din         (ch_din[0]),
        .ld_be          (ch_be[0]),
        .ld_rnw         (ch_rnw[0]),
        .ld_ack         (ch_ack[0])
    );

    for (genvar i = 0; i < NUM_CH; i++) begin : g_ch
        mem_channel u_ch (
            .clk_sys   (clk_sys),
            .rst_n     (rst_n),
            .req       (ch_req[i]),
            .addr      (ch_addr[i]),
            .din       (ch_din[i]),
            .be        (ch_be[i]),
            .rnw       (ch_rnw[i]),
            .ack       (ch_ack[i]),
            .dout      (ch_dout[i]),
            .pend      (pend[i]),
            .pend_addr (pend_addr[i]),
            .pend_din  (pend_din[i]),
            .pend_be   (pend_be[i]),
            .pend_rnw  (pend_rnw[i]),
            .done      (done[i]),
            .rdata     (arb_rdata)    // Shared, qualified by done
        );
    end

    mem_arbiter u_arb (
        .clk_sys   (clk_sys),
        .rst_n     (rst_n),
        .pend      (pend),
        .pend_addr (pend_addr),
        .pend_din  (pend_din),
        .pend_be   (pend_be),
        .pend_rnw  (pend_rnw),
        .done      (done),
        .rdata     (arb_rdata),
        .mem_start (mem_start),
        .mem_addr  (mem_addr),
        .mem_wdata (mem_wdata),
        .mem_be    (mem_be),
        .mem_rnw   (mem_rnw),
        .mem_valid (mem_valid),
        .mem_rdata (mem_rdata)
    );

    mem_store u_store (
        .clk_sys (clk_sys),
        .rst_n   (rst_n),
        .start   (mem_start),
        .addr    (mem_addr),
        .wdata   (mem_wdata),
        .be      (mem_be),
        .rnw     (mem_rnw),
        .valid   (mem_valid),
        .rdata   (mem_rdata)
    );

endmodule

//--- verif/tb_mem_subsys.sv
`timescale 1ns/1ps

module tb_mem_subsys import mem_pkg::*; ();

    localparam int RR_READS    = 4;      // Reads per client in the round-robin run
    localparam int DL_BYTES    = 256;
    localparam int MASK_OPS    = 200;
    localparam int CONC_OPS    = 60;     // Per client
    localparam int MEM_WORDS   = 2**ADDR_W;
    localparam int TOTAL_OPS   = 3*RR_READS + MEM_WORDS + 2*DL_BYTES + 2*MASK_OPS
                               + 3*CONC_OPS + 3;
    localparam int TIMEOUT_CYC = TOTAL_OPS * NUM_CH * (MEM_LAT + 3) + 2000;

    logic                          clk_sys;
    logic                          rst_n;
    logic                          ioctl_download;
    logic                          ioctl_wr;
    logic [LOAD_ADDR_W-1:0]        ioctl_addr;
    logic [BYTE_W-1:0]             ioctl_data;
    logic                          ioctl_wait;
    logic                          busy;
    logic [NUM_CH-1:1]             cl_req;
    logic [NUM_CH-1:1][ADDR_W-1:0] cl_addr;
    logic [NUM_CH-1:1][DATA_W-1:0] cl_din;
    logic [NUM_CH-1:1][BE_W-1:0]   cl_be;
    logic [NUM_CH-1:1]             cl_rnw;
    logic [NUM_CH-1:1]             cl_ack;
    logic [NUM_CH-1:1][DATA_W-1:0] cl_dout;

    logic [DATA_W-1:0] model [MEM_WORDS];    // Reference word memory
    bit                touched [MEM_WORDS];  // Words hit by the download
    logic [31:0]       seed = 32'd1;
    int                req_cnt [NUM_CH];
    int                ack_cnt [NUM_CH];
    int                ack_order [$];        // Channel of every ack rise
    bit                log_order;

    // Concurrent traffic, generated up front so the seed order is fixed
    logic [ADDR_W-1:0] conc_addr [NUM_CH][CONC_OPS];
    logic [DATA_W-1:0] conc_din  [NUM_CH][CONC_OPS];
    logic [BE_W-1:0]   conc_be   [NUM_CH][CONC_OPS];
    logic              conc_rnw  [NUM_CH][CONC_OPS];

    logic [NUM_CH-1:0] prev_req = '0;
    logic [NUM_CH-1:0] prev_ack = '0;

    mem_subsys_top uut (
        .clk_sys        (clk_sys),
        .rst_n          (rst_n),
        .ioctl_download (ioctl_download),
        .ioctl_wr       (ioctl_wr),
        .ioctl_addr     (ioctl_addr),
        .ioctl_data     (ioctl_data),
        .ioctl_wait     (ioctl_wait),
        .busy           (busy),
        .cl_req         (cl_req),
        .cl_addr        (cl_addr),
        .cl_din         (cl_din),
        .cl_be          (cl_be),
        .cl_rnw         (cl_rnw),
        .cl_ack         (cl_ack),
        .cl_dout        (cl_dout)
    );

    initial begin
        clk_sys = 1'b0;
        forever #10 clk_sys = ~clk_sys;    // 20 ns period
    end

    // ==================================================
    // Helpers
    // ==================================================

    task automatic check_equal(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (expected !== actual) begin
            $display("CHECK FAILED: %s expected 0x%0h actual 0x%0h", name, expected, actual);
            $display("sim failed");
            $fatal(1, "Stopped at first mismatch");
        end
    endtask

    function automatic logic [31:0] rand_next();
        seed = seed * 32'd1664525 + 32'd1013904223;    // Numerical Recipes LCG
        return seed;
    endfunction

    // Odd multiplier, so every address bit shows in the word
    function automatic logic [DATA_W-1:0] fill_word(input logic [ADDR_W-1:0] a);
        return (DATA_W'(a) * 16'h9e37) ^ 16'h5a5a;
    endfunction

    function automatic logic [BE_W-1:0] pick_be(input logic [31:0] r);
        case (r % 3)
            0:       return 2'b01;
            1:       return 2'b10;
            default: return 2'b11;
        endcase
    endfunction

    // Byte lane write rule
    task automatic model_write(input logic [ADDR_W-1:0] a, input logic [DATA_W-1:0] d,
                               input logic [BE_W-1:0] be);
        for (int b = 0; b < BE_W; b++) begin
            if (be[b]) model[a][b*BYTE_W +: BYTE_W] = d[b*BYTE_W +: BYTE_W];
        end
    endtask

    // One full four-phase cycle on a client channel
    task automatic access(input logic [CH_IDX_W-1:0] ch, input logic [ADDR_W-1:0] a,
                          input logic [DATA_W-1:0] d, input logic [BE_W-1:0] be,
                          input logic rnw, output logic [DATA_W-1:0] rd);
        @(negedge clk_sys);
        cl_addr[ch] = a;
        cl_din[ch]  = d;
        cl_be[ch]   = be;
        cl_rnw[ch]  = rnw;
        cl_req[ch]  = 1'b1;    // Phase 1
        req_cnt[ch]++;
        do @(negedge clk_sys); while (!cl_ack[ch]);
        rd = cl_dout[ch];
        cl_req[ch] = 1'b0;     // Phase 3
        do @(negedge clk_sys); while (cl_ack[ch]);
    endtask

    task automatic write_word(input logic [CH_IDX_W-1:0] ch, input logic [ADDR_W-1:0] a,
                              input logic [DATA_W-1:0] d, input logic [BE_W-1:0] be);
        logic [DATA_W-1:0] rd;
        model_write(a, d, be);    // Issue order
        access(ch, a, d, be, 1'b0, rd);
    endtask

    task automatic read_check(input string name, input logic [CH_IDX_W-1:0] ch,
                              input logic [ADDR_W-1:0] a);
        logic [DATA_W-1:0] exp;
        logic [DATA_W-1:0] rd;
        exp = model[a];
        access(ch, a, '0, '0, 1'b1, rd);
        check_equal(name, 32'(exp), 32'(rd));
    endtask

    // Host side of the download, stalls on ioctl_wait
    task automatic send_byte(input logic [LOAD_ADDR_W-1:0] la, input logic [BYTE_W-1:0] d);
        logic [ADDR_W-1:0] w;
        w = la[LOAD_ADDR_W-1:1];
        @(negedge clk_sys);
        while (ioctl_wait) @(negedge clk_sys);
        ioctl_addr = la;
        ioctl_data = d;
        ioctl_wr   = 1'b1;
        if (la[0]) model[w][BYTE_W +: BYTE_W] = d;    // Odd byte, high lane
        else model[w][0 +: BYTE_W] = d;
        touched[w] = 1'b1;
        @(negedge clk_sys);
        ioctl_wr = 1'b0;
    endtask

    task automatic fill_lane(input logic [CH_IDX_W-1:0] ch);
        for (int i = int'(ch) - 1; i < MEM_WORDS; i += NUM_CH - 1) begin
            write_word(ch, ADDR_W'(i), fill_word(ADDR_W'(i)), 2'b11);
        end
    endtask

    task automatic rr_lane(input logic [CH_IDX_W-1:0] ch);
        logic [DATA_W-1:0] rd;
        repeat (RR_READS) access(ch, ADDR_W'(ch), '0, '0, 1'b1, rd);    // Back to back
    endtask

    task automatic conc_lane(input logic [CH_IDX_W-1:0] ch);
        for (int k = 0; k < CONC_OPS; k++) begin
            if (conc_rnw[ch][k]) read_check("concurrent read", ch, conc_addr[ch][k]);
            else write_word(ch, conc_addr[ch][k], conc_din[ch][k], conc_be[ch][k]);
        end
    endtask

    task automatic count_check(input logic [CH_IDX_W-1:0] ch);
        check_equal("one ack per request", 32'(req_cnt[ch]), 32'(ack_cnt[ch]));
    endtask

    // ==================================================
    // Handshake monitor, samples pre-edge values
    // ==================================================

    always @(posedge clk_sys) begin
        for (int c = 1; c < NUM_CH; c++) begin
            if (cl_ack[c] && !prev_ack[c]) begin
                check_equal("ack rise with req high", 32'd1, 32'(prev_req[c]));
                ack_cnt[c]++;
                if (log_order) ack_order.push_back(c);
            end
            if (!cl_ack[c] && prev_ack[c]) begin
                check_equal("ack fall after req fall", 32'd0, 32'(prev_req[c]));
            end
            prev_req[c] = cl_req[c];
            prev_ack[c] = cl_ack[c];
        end
    end

    initial begin
        repeat (TIMEOUT_CYC) @(posedge clk_sys);
        $display("ERROR: simulation timed out after %0d cycles", TIMEOUT_CYC);
        $display("sim failed");
        $fatal(1, "Watchdog expired");
    end

    // ==================================================
    // Test sequence
    // ==================================================

    initial begin
        logic [31:0]         r;
        logic [ADDR_W-1:0]   a;
        logic [DATA_W-1:0]   x;
        logic [CH_IDX_W-1:0] ch;
        int                  n;

        rst_n          = 1'b0;
        ioctl_download = 1'b0;
        ioctl_wr       = 1'b0;
        ioctl_addr     = '0;
        ioctl_data     = '0;
        cl_req         = '0;
        cl_addr        = '0;
        cl_din         = '0;
        cl_be          = '0;
        cl_rnw         = '0;
        log_order      = 1'b0;
        repeat (4) @(posedge clk_sys);
        @(negedge clk_sys);
        rst_n = 1'b1;

        // Reset state
        @(negedge clk_sys);
        check_equal("reset cl_ack", 32'd0, 32'(cl_ack));
        check_equal("reset ioctl_wait", 32'd0, 32'(ioctl_wait));
        check_equal("reset busy", 32'd0, 32'(busy));

        // Round robin from idle, ch 0 searched first but empty
        log_order = 1'b1;
        fork
            rr_lane(2'd1);
            rr_lane(2'd2);
            rr_lane(2'd3);
        join
        log_order = 1'b0;
        check_equal("round robin ack count", 32'(3*RR_READS), 32'(ack_order.size()));
        for (int k = 0; k < 3*RR_READS; k++) begin
            check_equal("round robin order", 32'(1 + k % 3), 32'(ack_order[k]));
        end

        // Known contents before any partial write
        fork
            fill_lane(2'd1);
            fill_lane(2'd2);
            fill_lane(2'd3);
        join

        // ROM download
        @(negedge clk_sys);
        ioctl_download = 1'b1;
        for (int i = 0; i < DL_BYTES; i++) begin
            r = rand_next();
            send_byte(LOAD_ADDR_W'(r >> 21), BYTE_W'(r >> 8));
        end
        check_equal("busy during download", 32'd1, 32'(busy));
        @(negedge clk_sys);
        ioctl_download = 1'b0;
        while (busy) @(negedge clk_sys);    // Last write drains first
        n = 0;
        for (int w = 0; w < MEM_WORDS; w++) begin
            if (touched[w]) begin
                read_check("download readback", CH_IDX_W'(1 + n % 3), ADDR_W'(w));
                n++;
            end
        end

        // Masked writes, read back on another channel
        for (int i = 0; i < MASK_OPS; i++) begin
            r  = rand_next();
            ch = CH_IDX_W'(1 + r[31:24] % 3);
            a  = ADDR_W'(r >> 12);
            x  = DATA_W'(rand_next() >> 8);
            write_word(ch, a, x, pick_be(r));
            read_check("masked write", CH_IDX_W'(int'(ch) % 3 + 1), a);
        end

        // Concurrency on disjoint address sets, addr mod 3 picks the client
        for (int c = 1; c < NUM_CH; c++) begin
            for (int k = 0; k < CONC_OPS; k++) begin
                r = rand_next();
                conc_addr[c][k] = ADDR_W'((r[31:12] % (MEM_WORDS / 3)) * 3 + c - 1);
                conc_be[c][k]   = pick_be(r);
                conc_rnw[c][k]  = r[5];
                conc_din[c][k]  = DATA_W'(rand_next() >> 8);
            end
        end
        fork
            conc_lane(2'd1);
            conc_lane(2'd2);
            conc_lane(2'd3);
        join
        for (int c = 1; c < NUM_CH; c++) count_check(CH_IDX_W'(c));

        // Held req, ch 2 overwrites meanwhile so a repeat write would show
        a = ADDR_W'(rand_next() >> 12);
        x = DATA_W'(rand_next() >> 8);
        @(negedge clk_sys);
        cl_addr[1] = a;
        cl_din[1]  = x;
        cl_be[1]   = 2'b11;
        cl_rnw[1]  = 1'b0;
        cl_req[1]  = 1'b1;
        req_cnt[1]++;
        model_write(a, x, 2'b11);
        do @(negedge clk_sys); while (!cl_ack[1]);
        write_word(2'd2, a, ~x, 2'b11);
        repeat (8) begin
            @(negedge clk_sys);
            check_equal("held req keeps ack", 32'd1, 32'(cl_ack[1]));
        end
        cl_req[1] = 1'b0;
        do @(negedge clk_sys); while (cl_ack[1]);
        read_check("held req single write", 2'd3, a);
        for (int c = 1; c < NUM_CH; c++) count_check(CH_IDX_W'(c));

        $display("sim passed");
        $finish;
    end

endmodule

//--- sim.f
verilog/mem_pkg.sv
verilog/rom_loader.sv
verilog/mem_channel.sv
verilog/mem_arbiter.sv
verilog/mem_store.sv
verilog/mem_subsys_top.sv
verif/tb_mem_subsys.sv

//--- run_sim.sh
#!/bin/sh
# Verilator build and run of the memory subsystem testbench
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing -j 0 \
    --top-module tb_mem_subsys \
    -f sim.f \
    -o Vtb_mem_subsys

# Exit status of the model is ignored here, the log holds the verdict
./obj_dir/Vtb_mem_subsys > sim.log 2>&1 || true
cat sim.log

if grep -qx "sim passed" sim.log; then
    echo "RESULT: PASS"
else
    echo "RESULT: FAIL"
    exit 1
fi
